// ==== include/rob_defs.svh ====
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// tags are reorder buffer slot indices
`define ROB_DEPTH 16
`define TAG_W 4

`define XLEN 32

// store queue entries and the rob's starting store credits
`define STQ_DEPTH 4

// memory write credits held by the store queue at reset
`define MEM_CREDITS 2

`endif

// ==== verilog/robPkg.sv ====
`include "rob_defs.svh"
`default_nettype none

package robPkg;

    typedef logic [`TAG_W-1:0] tagT;
    typedef logic [4:0] regT;       // architectural register index
    typedef logic [`XLEN-1:0] dataT;

    // opcode class of an entry
    typedef enum logic [1:0] {
        kindAlu,
        kindStore,
        kindBranch
    } entryKindE;

    typedef enum logic [1:0] {
        stFree,
        stWaiting,   // allocated, no result yet
        stDone
    } entryStateE;

endpackage

`default_nettype wire

// ==== verilog/commitIfs.sv ====
`default_nettype none

// one cycle commit write from the rob into the rename file
interface regWriteIf;
    logic         valid;
    robPkg::regT  rd;
    robPkg::dataT data;
    robPkg::tagT  tag;   // rob slot of the retiring entry

    modport source (
        output valid,
        output rd,
        output data,
        output tag
    );

    modport sink (
        input valid,
        input rd,
        input data,
        input tag
    );
endinterface

// credit based path for committed stores
interface storeRetireIf;
    logic         valid;
    robPkg::dataT addr;
    robPkg::dataT data;
    logic         creditReturn;   // one pulse per store drained to memory

    modport source (
        output valid,
        output addr,
        output data,
        input  creditReturn
    );

    modport sink (
        input  valid,
        input  addr,
        input  data,
        output creditReturn
    );
endinterface

`default_nettype wire

// ==== verilog/reorderBuffer.sv ====
`include "rob_defs.svh"
`default_nettype none

module reorderBuffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              allocValid,
    input  robPkg::regT       allocRd,
    input  robPkg::entryKindE allocKind,
    input  logic              allocPredTaken,
    output robPkg::tagT       allocTag,
    output logic              full,
    input  logic              cplValid,
    input  robPkg::tagT       cplTag,
    input  robPkg::dataT      cplData,
    input  logic              cplTaken,
    input  robPkg::dataT      cplTarget,
    output logic              flush,
    output robPkg::dataT      flushPc,
    regWriteIf.source         regWr,
    storeRetireIf.source      stq
);
    localparam int CntW = $clog2(`ROB_DEPTH) + 1;
    localparam int CrdW = $clog2(`STQ_DEPTH) + 1;

    robPkg::entryStateE slotState [`ROB_DEPTH];
    robPkg::entryKindE  slotKind [`ROB_DEPTH];
    robPkg::regT        slotRd [`ROB_DEPTH];
    robPkg::dataT       slotData [`ROB_DEPTH];
    robPkg::dataT       slotTarget [`ROB_DEPTH];   // branch target or store address
    logic               slotTaken [`ROB_DEPTH];
    logic               slotPred [`ROB_DEPTH];

    robPkg::tagT     headPtr;
    robPkg::tagT     tailPtr;
    logic [CntW-1:0] count;
    logic [CrdW-1:0] storeCredits;

    logic allocFire;
    logic cplFire;
    logic headDone;
    logic headIsStore;
    logic retire;
    logic mispredict;
    logic storeFire;

    assign allocTag = tailPtr;
    assign full = (count == CntW'(`ROB_DEPTH));
    assign allocFire = allocValid && !full && !flush;   // dropped in the flush cycle
    assign cplFire = cplValid && (slotState[cplTag] == robPkg::stWaiting);

    assign headDone = (slotState[headPtr] == robPkg::stDone);
    assign headIsStore = (slotKind[headPtr] == robPkg::kindStore);
    // a store at the head waits for a queue credit
    assign retire = headDone && (!headIsStore || storeCredits != '0);
    assign storeFire = retire && headIsStore;
    assign mispredict = retire && (slotKind[headPtr] == robPkg::kindBranch)
                        && (slotTaken[headPtr] != slotPred[headPtr]);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                slotState[i] <= robPkg::stFree;
            end
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
            storeCredits <= CrdW'(`STQ_DEPTH);
            flush <= 1'b0;
            regWr.valid <= 1'b0;
            stq.valid <= 1'b0;
        end else begin
            flush <= mispredict;
            regWr.valid <= retire && !headIsStore && (slotRd[headPtr] != '0);
            stq.valid <= storeFire;
            storeCredits <= storeCredits - CrdW'(storeFire) + CrdW'(stq.creditReturn);

            if (mispredict) begin
                // drop everything younger than the branch
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    slotState[i] <= robPkg::stFree;
                end
                headPtr <= '0;
                tailPtr <= '0;
                count <= '0;
            end else begin
                if (cplFire) begin
                    slotState[cplTag] <= robPkg::stDone;
                end
                if (allocFire) begin
                    slotState[tailPtr] <= robPkg::stWaiting;
                    tailPtr <= tailPtr + 1'b1;   // wraps at depth
                end
                if (retire) begin
                    slotState[headPtr] <= robPkg::stFree;
                    headPtr <= headPtr + 1'b1;
                end
                count <= count + CntW'(allocFire) - CntW'(retire);
            end
        end
    end

    // entry payload and retire outputs
    always_ff @(posedge clk) begin
        if (allocFire) begin
            slotKind[tailPtr] <= allocKind;
            slotRd[tailPtr] <= allocRd;
            slotPred[tailPtr] <= allocPredTaken;
        end
        if (cplFire) begin
            slotData[cplTag] <= cplData;
            slotTaken[cplTag] <= cplTaken;
            slotTarget[cplTag] <= cplTarget;
        end
        if (retire) begin
            regWr.rd <= slotRd[headPtr];
            regWr.data <= slotData[headPtr];
            regWr.tag <= headPtr;
            stq.addr <= slotTarget[headPtr];
            stq.data <= slotData[headPtr];
        end
        if (mispredict) begin
            flushPc <= slotTarget[headPtr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/renameRegFile.sv ====
`default_nettype none

module renameRegFile (
    input  logic         clk,
    input  logic         rst,
    input  logic         allocValid,
    input  robPkg::regT  allocRd,
    input  robPkg::tagT  allocTag,
    input  logic         full,
    input  logic         flush,
    regWriteIf.sink      regWr,
    input  robPkg::regT  readReg,
    output robPkg::dataT readData,
    output logic         readBusy,
    output robPkg::tagT  readTag
);
    localparam int NumRegs = 2 ** $bits(robPkg::regT);

    robPkg::dataT       regVal [NumRegs];
    robPkg::tagT        regTag [NumRegs];   // youngest in-flight writer
    logic [NumRegs-1:0] busy;
    logic               allocFire;

    // same acceptance rule as the rob
    assign allocFire = allocValid && !full && !flush;

    assign readData = (readReg == '0) ? '0 : regVal[readReg];
    assign readBusy = busy[readReg];
    assign readTag = regTag[readReg];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regVal[i] <= '0;
            end
            busy <= '0;
        end else begin
            if (regWr.valid && regWr.rd != '0) begin
                regVal[regWr.rd] <= regWr.data;
                // a younger rename keeps the register busy
                if (regTag[regWr.rd] == regWr.tag) begin
                    busy[regWr.rd] <= 1'b0;
                end
            end
            if (flush) begin
                busy <= '0;
            end else if (allocFire && allocRd != '0) begin
                busy[allocRd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocFire && allocRd != '0) begin
            regTag[allocRd] <= allocTag;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/storeRetireQueue.sv ====
`include "rob_defs.svh"
`default_nettype none

module storeRetireQueue (
    input  logic         clk,
    input  logic         rst,
    storeRetireIf.sink   stq,
    input  logic         memCredit,
    output logic         memValid,
    output robPkg::dataT memAddr,
    output robPkg::dataT memData
);
    localparam int PtrW = $clog2(`STQ_DEPTH);
    localparam int CntW = PtrW + 1;
    localparam int MemW = $clog2(`MEM_CREDITS + 1);

    robPkg::dataT    addrMem [`STQ_DEPTH];
    robPkg::dataT    dataMem [`STQ_DEPTH];
    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [CntW-1:0] count;
    logic [MemW-1:0] memCredits;
    logic            pop;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
        return (p == PtrW'(`STQ_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop = (count != '0) && (memCredits != '0);

    // upstream credits guarantee space on push
    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
            memCredits <= MemW'(`MEM_CREDITS);
            memValid <= 1'b0;
            stq.creditReturn <= 1'b0;
        end else begin
            if (stq.valid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + CntW'(stq.valid) - CntW'(pop);
            memCredits <= memCredits - MemW'(pop) + MemW'(memCredit);
            memValid <= pop;
            stq.creditReturn <= pop;   // slot freed upstream
        end
    end

    always_ff @(posedge clk) begin
        if (stq.valid) begin
            addrMem[wrPtr] <= stq.addr;
            dataMem[wrPtr] <= stq.data;
        end
        if (pop) begin
            memAddr <= addrMem[rdPtr];
            memData <= dataMem[rdPtr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/commitCore.sv ====
`default_nettype none

module commitCore (
    input  logic              clk,
    input  logic              rst,
    input  logic              allocValid,
    input  robPkg::regT       allocRd,
    input  robPkg::entryKindE allocKind,
    input  logic              allocPredTaken,
    output robPkg::tagT       allocTag,
    output logic              full,
    input  logic              cplValid,
    input  robPkg::tagT       cplTag,
    input  robPkg::dataT      cplData,
    input  logic              cplTaken,
    input  robPkg::dataT      cplTarget,
    output logic              flush,
    output robPkg::dataT      flushPc,
    input  robPkg::regT       readReg,
    output robPkg::dataT      readData,
    output logic              readBusy,
    output robPkg::tagT       readTag,
    input  logic              memCredit,
    output logic              memValid,
    output robPkg::dataT      memAddr,
    output robPkg::dataT      memData
);
    regWriteIf    regWr ();
    storeRetireIf stq ();

    reorderBuffer reorderBuffer_i (
        .clk            (clk),
        .rst            (rst),
        .allocValid     (allocValid),
        .allocRd        (allocRd),
        .allocKind      (allocKind),
        .allocPredTaken (allocPredTaken),
        .allocTag       (allocTag),
        .full           (full),
        .cplValid       (cplValid),
        .cplTag         (cplTag),
        .cplData        (cplData),
        .cplTaken       (cplTaken),
        .cplTarget      (cplTarget),
        .flush          (flush),
        .flushPc        (flushPc),
        .regWr          (regWr.source),
        .stq            (stq.source)
    );

    renameRegFile renameRegFile_i (
        .clk        (clk),
        .rst        (rst),
        .allocValid (allocValid),
        .allocRd    (allocRd),
        .allocTag   (allocTag),
        .full       (full),
        .flush      (flush),
        .regWr      (regWr.sink),
        .readReg    (readReg),
        .readData   (readData),
        .readBusy   (readBusy),
        .readTag    (readTag)
    );

    // committed stores drain here and survive a flush
    storeRetireQueue storeRetireQueue_i (
        .clk       (clk),
        .rst       (rst),
        .stq       (stq.sink),
        .memCredit (memCredit),
        .memValid  (memValid),
        .memAddr   (memAddr),
        .memData   (memData)
    );

endmodule

`default_nettype wire

// ==== tb/commitCore_assertions.sv ====
`default_nettype none

// credit path of one producer and an output that stays quiet in reset
module commitCoreAssertions #(
    parameter int CntW = 2,
    parameter int MaxCredits = 2
) (
    input logic            clk,
    input logic            rst,
    input logic            fire,       // output pulse that spends one credit
    input logic            creditIn,   // one credit handed back
    input logic [CntW-1:0] credits,
    input logic            outValid
);
    int inFlight;   // pulses sent and not yet credited back

    always_ff @(posedge clk) begin
        if (rst) begin
            inFlight <= 0;
        end else begin
            inFlight <= inFlight + int'(fire) - int'(creditIn);
        end
    end

    quietInReset: assert property (@(posedge clk) rst |=> !outValid)
        else $error("valid output raised during reset");

    creditHeld: assert property (@(posedge clk) disable iff (rst) inFlight <= MaxCredits)
        else $error("more pulses outstanding than credits");

    creditLimit: assert property (@(posedge clk) disable iff (rst) int'(credits) <= MaxCredits)
        else $error("credit count above its initial value");

endmodule

`default_nettype wire

// ==== tb/commitCoreTb.sv ====
`include "rob_defs.svh"
`default_nettype none

module commitCoreTb;
    localparam int BatchOps = 12;
    localparam int NumBatches = 4;
    // normal batches, the flush batch and the full test with its rejected alloc
    localparam int NumOps = (NumBatches + 1) * BatchOps + `ROB_DEPTH + 1;

    logic              clk = 1'b0;
    logic              rst;
    logic              allocValid;
    robPkg::regT       allocRd;
    robPkg::entryKindE allocKind;
    logic              allocPredTaken;
    robPkg::tagT       allocTag;
    logic              full;
    logic              cplValid;
    robPkg::tagT       cplTag;
    robPkg::dataT      cplData;
    logic              cplTaken;
    robPkg::dataT      cplTarget;
    logic              flush;
    robPkg::dataT      flushPc;
    robPkg::regT       readReg;
    robPkg::dataT      readData;
    logic              readBusy;
    robPkg::tagT       readTag;
    logic              memCredit;
    logic              memValid;
    robPkg::dataT      memAddr;
    robPkg::dataT      memData;

    // current batch in program order
    robPkg::entryKindE bKind [`ROB_DEPTH];
    robPkg::regT       bRd [`ROB_DEPTH];
    robPkg::dataT      bData [`ROB_DEPTH];
    robPkg::dataT      bTarget [`ROB_DEPTH];   // store address or branch target
    logic              bPred [`ROB_DEPTH];
    logic              bTaken [`ROB_DEPTH];
    robPkg::tagT       bTag [`ROB_DEPTH];
    int                order [`ROB_DEPTH];

    robPkg::dataT expReg [32];
    robPkg::dataT expAddr [$];
    robPkg::dataT expData [$];
    robPkg::dataT expFlushPc [$];
    robPkg::tagT  expTag = '0;       // next slot the rob should hand out
    int           errors = 0;
    int           outstanding = 0;   // memory writes not yet credited back

    commitCore commitCore_i (.*);

    bind reorderBuffer commitCoreAssertions #(
        .CntW       (CrdW),
        .MaxCredits (`STQ_DEPTH)
    ) robChecks (
        .clk      (clk),
        .rst      (rst),
        .fire     (stq.valid),
        .creditIn (stq.creditReturn),
        .credits  (storeCredits),
        .outValid (flush)
    );

    bind storeRetireQueue commitCoreAssertions #(
        .CntW       (MemW),
        .MaxCredits (`MEM_CREDITS)
    ) stqChecks (
        .clk      (clk),
        .rst      (rst),
        .fire     (memValid),
        .creditIn (memCredit),
        .credits  (memCredits),
        .outValid (memValid)
    );

    always #50 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic reportError(input string msg);
        $display("ERROR: %s", msg);
        errors++;
    endtask

    // architectural effect of n entries up to the first mispredicted branch
    function automatic void modelBatch(input int n);
        for (int i = 0; i < n; i++) begin
            if (bKind[i] == robPkg::kindStore) begin
                expAddr.push_back(bTarget[i]);
                expData.push_back(bData[i]);
            end else if (bRd[i] != '0) begin
                expReg[bRd[i]] = bData[i];
            end
            if (bKind[i] == robPkg::kindBranch && bTaken[i] != bPred[i]) begin
                expFlushPc.push_back(bTarget[i]);
                break;
            end
        end
    endfunction

    task automatic fillBatch(input int n, input int badBranch);
        for (int i = 0; i < n; i++) begin
            bKind[i] = robPkg::entryKindE'($urandom % 3);
            bRd[i] = robPkg::regT'($urandom);
            bData[i] = $urandom;
            bTarget[i] = $urandom;
            bPred[i] = 1'($urandom);
            if (i == badBranch) begin
                bKind[i] = robPkg::kindBranch;
            end else if (i == n - 1) begin
                // youngest entry renames a register to make idle observable
                bKind[i] = robPkg::kindAlu;
                bRd[i] = robPkg::regT'(1 + $urandom % 31);
            end
            if (bKind[i] == robPkg::kindStore) begin
                bRd[i] = '0;
            end
            bTaken[i] = (i == badBranch) ? !bPred[i] : bPred[i];
        end
    endtask

    task automatic allocOne(input int i);
        allocValid = 1'b1;
        allocRd = bRd[i];
        allocKind = bKind[i];
        allocPredTaken = bPred[i];
        readReg = bRd[i];
        checkValue("allocTag", 32'(allocTag), 32'(expTag));
        bTag[i] = expTag;
        @(negedge clk);
        allocValid = 1'b0;
        expTag = expTag + 1'b1;   // slots are handed out in order
        if (bRd[i] != '0) begin
            checkValue("readBusy", 32'(readBusy), 32'd1);
            checkValue("readTag", 32'(readTag), 32'(bTag[i]));
        end
    endtask

    // completes entries first..n-1 in a shuffled order
    task automatic completeRandom(input int first, input int n);
        int j;
        int tmp;
        for (int i = first; i < n; i++) begin
            order[i] = i;
        end
        for (int i = n - 1; i > first; i--) begin
            j = first + int'($urandom % (i - first + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = first; i < n; i++) begin
            cplValid = 1'b1;
            cplTag = bTag[order[i]];
            cplData = bData[order[i]];
            cplTaken = bTaken[order[i]];
            cplTarget = bTarget[order[i]];
            @(negedge clk);
        end
        cplValid = 1'b0;
    endtask

    // busy bits only fall without allocations and one clean sweep is enough
    task automatic waitIdle();
        logic clean;
        clean = 1'b0;
        while (!clean) begin
            clean = 1'b1;
            for (int r = 1; r < 32; r++) begin
                readReg = robPkg::regT'(r);
                @(negedge clk);
                if (readBusy) begin
                    clean = 1'b0;
                end
            end
        end
        while (expAddr.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic checkState();
        for (int r = 0; r < 32; r++) begin
            readReg = robPkg::regT'(r);
            @(negedge clk);
            checkValue($sformatf("readData[x%0d]", r), readData, expReg[r]);
            checkValue($sformatf("readBusy[x%0d]", r), 32'(readBusy), 32'd0);
        end
    endtask

    task automatic runBatch(input int badBranch);
        fillBatch(BatchOps, badBranch);
        modelBatch(BatchOps);
        for (int i = 0; i < BatchOps; i++) begin
            allocOne(i);
        end
        completeRandom(0, BatchOps);
        waitIdle();
        checkState();
    endtask

    task automatic fullTest();
        logic        oldBusy;
        robPkg::tagT oldTag;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            bKind[i] = robPkg::kindAlu;
            bRd[i] = robPkg::regT'(i + 1);
            bData[i] = $urandom;
            bTarget[i] = '0;
            bPred[i] = 1'b0;
            bTaken[i] = 1'b0;
        end
        modelBatch(`ROB_DEPTH);
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            allocOne(i);
        end
        checkValue("full", 32'(full), 32'd1);
        readReg = robPkg::regT'(20);   // not renamed by this test
        @(negedge clk);
        oldBusy = readBusy;
        oldTag = readTag;
        allocValid = 1'b1;
        allocRd = robPkg::regT'(20);
        allocKind = robPkg::kindAlu;
        @(negedge clk);
        allocValid = 1'b0;
        checkValue("readBusy[x20]", 32'(readBusy), 32'(oldBusy));
        checkValue("readTag[x20]", 32'(readTag), 32'(oldTag));
        completeRandom(0, 1);   // head only
        while (full) begin
            @(negedge clk);
        end
        completeRandom(1, `ROB_DEPTH);
        waitIdle();
        checkState();
    endtask

    // memory model that checks each write and returns credits late
    always @(negedge clk) begin
        memCredit = 1'b0;
        if (memValid) begin
            outstanding++;
            if (outstanding > `MEM_CREDITS) begin
                reportError("more memory writes outstanding than credits");
            end
            if (expAddr.size() == 0) begin
                reportError("memory write with no committed store left");
            end else begin
                checkValue("memAddr", memAddr, expAddr.pop_front());
                checkValue("memData", memData, expData.pop_front());
            end
        end
        if (flush) begin
            if (expFlushPc.size() == 0) begin
                reportError("flush without a mispredicted branch");
            end else begin
                checkValue("flushPc", flushPc, expFlushPc.pop_front());
            end
            expTag = '0;   // rob pointers restart after a flush
        end
        if (outstanding > 0 && $urandom % 4 == 0) begin
            memCredit = 1'b1;
            outstanding--;
        end
    end

    initial begin
        repeat (NumOps * 40) @(posedge clk);
        $display("timeout: run did not end within %0d cycles", NumOps * 40);
        $display("Test failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        allocValid = 1'b0;
        allocRd = '0;
        allocKind = robPkg::kindAlu;
        allocPredTaken = 1'b0;
        cplValid = 1'b0;
        cplTag = '0;
        cplData = '0;
        cplTaken = 1'b0;
        cplTarget = '0;
        readReg = '0;
        memCredit = 1'b0;
        void'($urandom(31));
        for (int r = 0; r < 32; r++) begin
            expReg[r] = '0;
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;

        for (int b = 0; b < NumBatches; b++) begin
            runBatch(-1);
        end
        fullTest();
        runBatch(BatchOps / 2);   // branch in the middle mispredicts

        if (expFlushPc.size() != 0) begin
            reportError("mispredicted branch retired without a flush");
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
verilog/robPkg.sv
verilog/commitIfs.sv
verilog/reorderBuffer.sv
verilog/renameRegFile.sv
verilog/storeRetireQueue.sv
verilog/commitCore.sv
tb/commitCore_assertions.sv
tb/commitCoreTb.sv

// ==== Makefile ====
TOP := commitCoreTb

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
